// ==== hw/convPkg.sv ====
package convPkg;

    localparam int sampleWidth = 16;                // Pixel and coefficient bits
    localparam int accWidth = 40;                   // Nine 32-bit products without overflow
    localparam int laneCount = 3;                   // Multiplier lanes, also taps per row
    localparam int windowTaps = 9;                  // 3x3 kernel
    localparam int fifoDepth = 16;                  // Intake FIFO entries

    localparam int tapWidth = $clog2(windowTaps);   // Tap index and coef pointer bits
    localparam int fifoAddrWidth = $clog2(fifoDepth);
    localparam int countWidth = fifoAddrWidth + 1;  // Holds 0 to fifoDepth

    // Index of the last tap, used for wraps and window end
    localparam logic [tapWidth-1:0] lastTap = tapWidth'(windowTaps - 1);

    typedef logic signed [sampleWidth-1:0] sample_t;   // Pixel or coefficient
    typedef logic signed [accWidth-1:0] acc_t;         // Row sum and window sum

endpackage

// ==== hw/busPkg.sv ====
package busPkg;

    localparam int addrWidth = 2;                   // Word address, four registers

    // Register map
    localparam logic [addrWidth-1:0] regSample = 2'd0;   // Write pushes a pixel
    localparam logic [addrWidth-1:0] regCoef = 2'd1;     // Write loads next coefficient
    localparam logic [addrWidth-1:0] regControl = 2'd2;  // Bit 0 starts, read gives status
    localparam logic [addrWidth-1:0] regResult = 2'd3;   // Read gives result low word

    // Status word bit positions
    localparam int statReady = 0;                   // Result valid
    localparam int statBusy = 1;                    // Window in progress
    localparam int statFull = 2;                    // Intake FIFO full
    localparam int statEmpty = 3;                   // Intake FIFO empty

endpackage

// ==== hw/laneIf.sv ====
interface laneIf;

    convPkg::sample_t sample;                       // FIFO read data
    logic sampleValid;                              // Sample present this cycle
    logic [convPkg::tapWidth-1:0] tap;              // Tap index of current sample
    convPkg::acc_t rowSum;                          // Sum of one kernel row
    logic rowValid;                                 // Row sum present this cycle

    modport lanes (
        input  sample,
        input  sampleValid,
        input  tap,
        output rowSum,
        output rowValid
    );

    modport acc (
        input  rowSum,
        input  rowValid
    );

endinterface

// ==== hw/convBusPort.sv ====
module convBusPort (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_wbCyc,
    input  logic                             i_wbStb,
    input  logic                             i_wbWe,
    input  logic [busPkg::addrWidth-1:0]     i_wbAdr,
    input  logic [convPkg::sampleWidth-1:0]  i_wbDat,
    output logic [convPkg::sampleWidth-1:0]  o_wbDat,
    output logic                             o_wbAck,
    input  logic                             i_fifoFull,
    output logic                             o_fifoPush,
    output convPkg::sample_t                 o_pushData,
    output logic                             o_coefWrite,
    output logic [convPkg::tapWidth-1:0]     o_coefIndex,
    output convPkg::sample_t                 o_coefData,
    output logic                             o_startReq,
    input  logic                             i_busy,
    input  logic                             i_ready,
    input  logic                             i_fifoEmpty,
    input  logic [convPkg::sampleWidth-1:0]  i_result
);

    logic request;                                  // New cycle, not yet acked
    logic accept;                                   // Request taken this cycle
    logic writeAccept;
    logic [convPkg::tapWidth-1:0] loadPtr;          // Next coefficient slot
    logic [convPkg::sampleWidth-1:0] status;

    assign request = i_wbCyc && i_wbStb && !o_wbAck;
    // Sample write waits while FIFO is full
    assign accept = request && !(i_wbWe && i_wbAdr == busPkg::regSample && i_fifoFull);
    assign writeAccept = accept && i_wbWe;

    assign o_fifoPush = writeAccept && i_wbAdr == busPkg::regSample;
    assign o_pushData = i_wbDat;
    assign o_coefWrite = writeAccept && i_wbAdr == busPkg::regCoef;
    assign o_coefIndex = loadPtr;
    assign o_coefData = i_wbDat;
    assign o_startReq = writeAccept && i_wbAdr == busPkg::regControl && i_wbDat[0]
        && !i_busy;                                 // Start ignored mid-window

    always_comb begin
        status = '0;
        status[busPkg::statReady] = i_ready;
        status[busPkg::statBusy] = i_busy;
        status[busPkg::statFull] = i_fifoFull;
        status[busPkg::statEmpty] = i_fifoEmpty;
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            o_wbAck <= 1'b0;
            loadPtr <= '0;
        end else begin
            o_wbAck <= accept;                      // One cycle after request seen
            if (o_startReq) begin
                loadPtr <= '0;                      // Next kernel load starts at tap 0
            end else if (o_coefWrite) begin
                loadPtr <= (loadPtr == convPkg::lastTap) ? '0 : loadPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (accept && !i_wbWe) begin
            case (i_wbAdr)
                busPkg::regControl: o_wbDat <= status;
                busPkg::regResult:  o_wbDat <= i_result;
                default:            o_wbDat <= '0;   // Write-only registers
            endcase
        end
    end

    // Classic cycle ends on ack, so ack is a single-cycle pulse
    assert property (@(posedge Clk) disable iff (i_reset) o_wbAck |=> !o_wbAck);

endmodule

// ==== hw/sampleFifo.sv ====
module sampleFifo (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_push,
    input  convPkg::sample_t                 i_pushData,
    input  logic                             i_pop,
    output convPkg::sample_t                 o_popData,
    output logic                             o_full,
    output logic                             o_empty,
    output logic [convPkg::countWidth-1:0]   o_count
);

    convPkg::sample_t mem [convPkg::fifoDepth];     // Circular buffer
    logic [convPkg::fifoAddrWidth-1:0] wrPtr;       // Wraps naturally at depth
    logic [convPkg::fifoAddrWidth-1:0] rdPtr;
    logic [convPkg::countWidth-1:0] count;

    assign o_full = count == convPkg::fifoDepth;
    assign o_empty = count == 0;
    assign o_count = count;

    always_ff @(posedge Clk) begin
        if (i_push) begin
            mem[wrPtr] <= i_pushData;
        end
        if (i_pop) begin
            o_popData <= mem[rdPtr];                // Valid the cycle after pop
        end
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (i_push) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (i_pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;            // Both or neither
            endcase
        end
    end

    // Bus port must stall on full, controller must wait for data
    assert property (@(posedge Clk) disable iff (i_reset) i_push |-> !o_full);
    assert property (@(posedge Clk) disable iff (i_reset) i_pop |-> !o_empty);

endmodule

// ==== hw/tapCounter.sv ====
module tapCounter (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_clear,
    input  logic                             i_step,
    output logic [convPkg::tapWidth-1:0]     o_tap,
    output logic                             o_rowEnd,
    output logic                             o_windowEnd
);

    // Last column of a row, taps 2, 5 and 8
    assign o_rowEnd = (o_tap % convPkg::laneCount) == convPkg::laneCount - 1;
    assign o_windowEnd = o_tap == convPkg::lastTap;

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            o_tap <= '0;
        end else if (i_clear) begin
            o_tap <= '0;                            // New window from tap 0
        end else if (i_step) begin
            o_tap <= o_windowEnd ? '0 : o_tap + 1'b1;   // Wrap after tap 8
        end
    end

endmodule

// ==== hw/convControl.sv ====
module convControl (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_startReq,
    input  logic [convPkg::countWidth-1:0]   i_fifoCount,
    input  logic                             i_windowEnd,
    input  logic                             i_accDone,
    output logic                             o_pop,
    output logic                             o_sampleValid,
    output logic                             o_clearTaps,
    output logic                             o_busy,
    output logic                             o_ready
);

    enum logic [2:0] {idle, waitData, fetch, drain, ready} state;

    logic [convPkg::tapWidth-1:0] popCount;         // Pops issued this window
    logic startAccept;

    assign startAccept = i_startReq && (state == idle || state == ready);
    assign o_clearTaps = startAccept;               // Also clears the accumulator
    assign o_pop = state == fetch && popCount <= convPkg::lastTap;   // Nine pops
    assign o_busy = state == waitData || state == fetch || state == drain;
    assign o_ready = state == ready;

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            state <= idle;
            popCount <= '0;
            o_sampleValid <= 1'b0;
        end else begin
            o_sampleValid <= o_pop;                 // Matches FIFO read latency
            if (startAccept) begin
                popCount <= '0;
            end else if (o_pop) begin
                popCount <= popCount + 1'b1;
            end
            case (state)
                idle, ready: begin
                    if (startAccept) begin
                        state <= waitData;
                    end
                end
                waitData: begin
                    if (i_fifoCount >= convPkg::windowTaps) begin
                        state <= fetch;             // Whole window buffered
                    end
                end
                fetch: begin
                    if (i_windowEnd && o_sampleValid) begin
                        state <= drain;             // Tap 8 in the lanes
                    end
                end
                drain: begin
                    if (i_accDone) begin
                        state <= ready;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Pops come only from fetch, and the FIFO holds data for each
    assert property (@(posedge Clk) disable iff (i_reset)
        o_pop |-> state == fetch && i_fifoCount != '0);

endmodule

// ==== hw/macLanes.sv ====
module macLanes (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_coefWrite,
    input  logic [convPkg::tapWidth-1:0]     i_coefIndex,
    input  convPkg::sample_t                 i_coefData,
    laneIf.lanes                             lanes
);

    convPkg::sample_t coef [convPkg::windowTaps];          // Kernel bank
    convPkg::sample_t laneReg [convPkg::laneCount-1];      // Earlier samples of the row
    convPkg::sample_t operand [convPkg::laneCount];        // Lane inputs at row end
    logic signed [2*convPkg::sampleWidth-1:0] product [convPkg::laneCount];
    logic productValid;
    logic rowEnd;
    convPkg::acc_t rowTotal;

    assign rowEnd = (lanes.tap % convPkg::laneCount) == convPkg::laneCount - 1;

    always_comb begin
        for (int i = 0; i < convPkg::laneCount - 1; i++) begin
            operand[i] = laneReg[i];
        end
        operand[convPkg::laneCount-1] = lanes.sample;   // Third sample straight in
        rowTotal = '0;
        for (int i = 0; i < convPkg::laneCount; i++) begin
            rowTotal = rowTotal + product[i];       // Sign extends to 40 bits
        end
    end

    always_ff @(posedge Clk) begin
        if (i_coefWrite) begin
            coef[i_coefIndex] <= i_coefData;
        end
        if (lanes.sampleValid) begin
            for (int i = 0; i < convPkg::laneCount - 2; i++) begin
                laneReg[i] <= laneReg[i+1];         // Shift toward lane 0
            end
            laneReg[convPkg::laneCount-2] <= lanes.sample;
        end
        if (lanes.sampleValid && rowEnd) begin
            for (int i = 0; i < convPkg::laneCount; i++) begin
                // Row base is tap minus 2
                product[i] <= operand[i] * coef[lanes.tap + i - (convPkg::laneCount - 1)];
            end
        end
        if (productValid) begin
            lanes.rowSum <= rowTotal;
        end
    end

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            productValid <= 1'b0;
            lanes.rowValid <= 1'b0;
        end else begin
            productValid <= lanes.sampleValid && rowEnd;   // Multiply stage
            lanes.rowValid <= productValid;                // Add stage
        end
    end

endmodule

// ==== hw/rowAccumulator.sv ====
module rowAccumulator (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_clear,
    laneIf.acc                               acc,
    output convPkg::acc_t                    o_result,
    output logic                             o_done
);

    logic [$clog2(convPkg::laneCount)-1:0] rowCount;   // Rows summed so far
    logic lastRow;

    assign lastRow = rowCount == convPkg::laneCount - 1;

    always_ff @(posedge Clk) begin
        if (i_reset) begin
            rowCount <= '0;
            o_done <= 1'b0;
            o_result <= '0;
        end else begin
            o_done <= acc.rowValid && lastRow;      // Pulse after third row
            if (i_clear) begin
                rowCount <= '0;
                o_result <= '0;                     // Start of a new window
            end else if (acc.rowValid) begin
                o_result <= o_result + acc.rowSum;
                rowCount <= lastRow ? '0 : rowCount + 1'b1;
            end
        end
    end

endmodule

// ==== hw/convTop.sv ====
module convTop (
    input  logic                             Clk,
    input  logic                             i_reset,
    input  logic                             i_wbCyc,
    input  logic                             i_wbStb,
    input  logic                             i_wbWe,
    input  logic [busPkg::addrWidth-1:0]     i_wbAdr,
    input  logic [convPkg::sampleWidth-1:0]  i_wbDat,
    output logic [convPkg::sampleWidth-1:0]  o_wbDat,
    output logic                             o_wbAck,
    output logic                             o_ready,
    output logic [convPkg::sampleWidth-1:0]  o_finalSum,
    output logic                             o_full,
    output logic                             o_empty
);

    laneIf laneBus ();                              // Lanes to accumulator

    logic fifoPush;
    convPkg::sample_t pushData;
    logic coefWrite;
    logic [convPkg::tapWidth-1:0] coefIndex;
    convPkg::sample_t coefData;
    logic startReq;
    logic busy;
    logic pop;
    logic clearTaps;
    logic windowEnd;
    logic accDone;
    logic [convPkg::countWidth-1:0] fifoCount;
    convPkg::acc_t result;

    // Result only shown while ready
    assign o_finalSum = o_ready ? result[convPkg::sampleWidth-1:0] : '0;

    convBusPort busPort (
        .Clk(Clk), .i_reset(i_reset),
        .i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
        .i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat), .o_wbDat(o_wbDat), .o_wbAck(o_wbAck),
        .i_fifoFull(o_full), .o_fifoPush(fifoPush), .o_pushData(pushData),
        .o_coefWrite(coefWrite), .o_coefIndex(coefIndex), .o_coefData(coefData),
        .o_startReq(startReq), .i_busy(busy), .i_ready(o_ready),
        .i_fifoEmpty(o_empty), .i_result(o_finalSum)
    );

    sampleFifo intakeFifo (
        .Clk(Clk), .i_reset(i_reset),
        .i_push(fifoPush), .i_pushData(pushData),
        .i_pop(pop), .o_popData(laneBus.sample),    // Pixel feed to lanes
        .o_full(o_full), .o_empty(o_empty), .o_count(fifoCount)
    );

    convControl control (
        .Clk(Clk), .i_reset(i_reset),
        .i_startReq(startReq), .i_fifoCount(fifoCount),
        .i_windowEnd(windowEnd), .i_accDone(accDone),
        .o_pop(pop), .o_sampleValid(laneBus.sampleValid),
        .o_clearTaps(clearTaps), .o_busy(busy), .o_ready(o_ready)
    );

    // Lanes find row ends from the tap index themselves
    tapCounter taps (
        .Clk(Clk), .i_reset(i_reset),
        .i_clear(clearTaps), .i_step(laneBus.sampleValid),
        .o_tap(laneBus.tap), .o_rowEnd(), .o_windowEnd(windowEnd)
    );

    macLanes mac (
        .Clk(Clk), .i_reset(i_reset),
        .i_coefWrite(coefWrite), .i_coefIndex(coefIndex), .i_coefData(coefData),
        .lanes(laneBus)
    );

    rowAccumulator accum (
        .Clk(Clk), .i_reset(i_reset), .i_clear(clearTaps),
        .acc(laneBus), .o_result(result), .o_done(accDone)
    );

endmodule

// ==== verif/convTb.sv ====
module convTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 16;
    localparam int testCount = 5;
    localparam int cyclesPerTest = 200;             // Budget per test for the watchdog
    localparam int stallCycles = 8;                 // How long the 17th write is held

    logic Clk;
    logic i_reset;
    logic i_wbCyc;
    logic i_wbStb;
    logic i_wbWe;
    logic [busPkg::addrWidth-1:0] i_wbAdr;
    logic [convPkg::sampleWidth-1:0] i_wbDat;
    logic [convPkg::sampleWidth-1:0] o_wbDat;
    logic o_wbAck;
    logic o_ready;
    logic [convPkg::sampleWidth-1:0] o_finalSum;
    logic o_full;
    logic o_empty;

    convPkg::sample_t coefModel [convPkg::windowTaps];  // Kernel as loaded
    convPkg::sample_t sampleModel [$];              // Pixels written, not yet windowed
    logic [convPkg::sampleWidth-1:0] expSum;        // Expected result of last start
    string currentTest = "reset";
    int pushedTotal;                                // Acked sample writes
    int windowsStarted;                             // Acked start writes
    logic expectFull;                               // Set once 16 samples are waiting
    logic [3:0] expStatus;
    logic [3:0] statusPrev;                         // Status at the read's accept cycle
    logic [convPkg::sampleWidth-1:0] resultPrev;
    logic fullPrev;
    logic reqWe;                                    // Bus request at its accept cycle
    logic [busPkg::addrWidth-1:0] reqAdr;
    logic [convPkg::sampleWidth-1:0] reqDat;

    convTop i_dut (
        .Clk(Clk), .i_reset(i_reset),
        .i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
        .i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat), .o_wbDat(o_wbDat), .o_wbAck(o_wbAck),
        .o_ready(o_ready), .o_finalSum(o_finalSum), .o_full(o_full), .o_empty(o_empty)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;                     // 100 ns period
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic reportMismatch(input string check, input logic [31:0] expected,
                                  input logic [31:0] actual);
        abortRun($sformatf("ERROR test %s, %s: expected 0x%0h actual 0x%0h",
                           currentTest, check, expected, actual));
    endtask

    // Bus side model, counted off the acks
    always @(posedge Clk) begin
        if (i_reset) begin
            pushedTotal <= 0;
            windowsStarted <= 0;
        end else if (o_wbAck && reqWe && reqAdr == busPkg::regSample) begin
            pushedTotal <= pushedTotal + 1;
        end else if (o_wbAck && reqWe && reqAdr == busPkg::regControl && reqDat[0]) begin
            windowsStarted <= windowsStarted + 1;
        end
    end

    always_comb begin
        expStatus = '0;
        expStatus[busPkg::statReady] = o_ready;
        expStatus[busPkg::statBusy] = windowsStarted != 0 && !o_ready;   // Start seen, no result
        expStatus[busPkg::statFull] = o_full;
        expStatus[busPkg::statEmpty] = o_empty;
    end

    always @(posedge Clk) begin
        statusPrev <= expStatus;                    // Read data is registered at accept
        resultPrev <= o_ready ? expSum : '0;
        fullPrev <= o_full;
        reqWe <= i_wbWe;                            // Master drops the bus before the ack edge
        reqAdr <= i_wbAdr;
        reqDat <= i_wbDat;
    end

    resetState: assert property (@(posedge Clk) $fell(i_reset) |->
        {o_ready, o_empty, o_full, o_wbAck, o_finalSum} == {4'b0100, 16'h0})
        else reportMismatch("reset state", {4'b0100, 16'h0},
                            $sampled({o_ready, o_empty, o_full, o_wbAck, o_finalSum}));
    windowResult: assert property (@(posedge Clk) disable iff (i_reset)
        $rose(o_ready) |-> o_finalSum == expSum)
        else reportMismatch("window result", $sampled(expSum), $sampled(o_finalSum));
    resultGated: assert property (@(posedge Clk) disable iff (i_reset)
        !o_ready |-> o_finalSum == '0)
        else reportMismatch("result while not ready", 0, $sampled(o_finalSum));
    readyAfterData: assert property (@(posedge Clk) disable iff (i_reset)
        $rose(o_ready) |-> pushedTotal >= convPkg::windowTaps * windowsStarted)
        else reportMismatch("samples before ready", convPkg::windowTaps * windowsStarted,
                            $sampled(pushedTotal));
    statusRead: assert property (@(posedge Clk) disable iff (i_reset)
        o_wbAck && !reqWe && reqAdr == busPkg::regControl |-> o_wbDat[3:0] == statusPrev)
        else reportMismatch("status read", $sampled(statusPrev), $sampled(o_wbDat));
    resultRead: assert property (@(posedge Clk) disable iff (i_reset)
        o_wbAck && !reqWe && reqAdr == busPkg::regResult |-> o_wbDat == resultPrev)
        else reportMismatch("result read", $sampled(resultPrev), $sampled(o_wbDat));
    fullFlag: assert property (@(posedge Clk) disable iff (i_reset) expectFull |-> o_full)
        else abortRun("Intake FIFO not flagged full after 16 sample writes");
    stallWhileFull: assert property (@(posedge Clk) disable iff (i_reset)
        o_wbAck && reqWe && reqAdr == busPkg::regSample |-> !fullPrev)
        else abortRun("Sample write was acked while the intake FIFO was full");

    task automatic busIdle();
        i_wbCyc = 1'b0;
        i_wbStb = 1'b0;
        i_wbWe = 1'b0;
    endtask

    task automatic wbWrite(input logic [busPkg::addrWidth-1:0] adr,
                           input logic [convPkg::sampleWidth-1:0] dat);
        @(negedge Clk);
        i_wbCyc = 1'b1;
        i_wbStb = 1'b1;
        i_wbWe = 1'b1;
        i_wbAdr = adr;
        i_wbDat = dat;
        do @(negedge Clk); while (!o_wbAck);        // Held until ack
        busIdle();
    endtask

    task automatic wbRead(input logic [busPkg::addrWidth-1:0] adr,
                          output logic [convPkg::sampleWidth-1:0] dat);
        @(negedge Clk);
        i_wbCyc = 1'b1;
        i_wbStb = 1'b1;
        i_wbWe = 1'b0;
        i_wbAdr = adr;
        do @(negedge Clk); while (!o_wbAck);
        dat = o_wbDat;
        busIdle();
    endtask

    // Write that gives up without ack, cycle dropped by the master
    task automatic tryWrite(input logic [busPkg::addrWidth-1:0] adr,
                            input logic [convPkg::sampleWidth-1:0] dat,
                            input int maxCycles, output logic acked);
        acked = 1'b0;
        @(negedge Clk);
        i_wbCyc = 1'b1;
        i_wbStb = 1'b1;
        i_wbWe = 1'b1;
        i_wbAdr = adr;
        i_wbDat = dat;
        for (int n = 0; n < maxCycles && !acked; n++) begin
            @(negedge Clk);
            acked = o_wbAck;
        end
        busIdle();
    endtask

    // Takes the next nine modeled pixels as the window, then starts
    task automatic startWindow();
        longint sum;
        sum = 0;
        for (int k = 0; k < convPkg::windowTaps; k++) begin
            sum += longint'(sampleModel.pop_front()) * longint'(coefModel[k]);
        end
        expSum = sum[convPkg::sampleWidth-1:0];     // Low word only
        wbWrite(busPkg::regControl, 16'h0001);
    endtask

    task automatic waitReady();
        do @(negedge Clk); while (!o_ready);        // Watchdog bounds this
    endtask

    function automatic convPkg::sample_t randomSample();
        return convPkg::sample_t'($urandom);
    endfunction

    function automatic convPkg::sample_t extremeSample();
        case ($urandom % 3)
            0:       return 16'sh8000;              // Most negative
            1:       return 16'sh7fff;
            default: return randomSample();
        endcase
    endfunction

    initial begin
        repeat (resetCycles + testCount * cyclesPerTest) @(posedge Clk);
        abortRun("Timeout: the tests did not finish within the cycle budget");
    end

    initial begin
        convPkg::sample_t batch [17];
        convPkg::sample_t s;
        logic [convPkg::sampleWidth-1:0] data;
        logic acked;
        void'($urandom(30660));                     // Fixed seed
        i_reset = 1'b1;
        i_wbAdr = '0;
        i_wbDat = '0;
        expSum = '0;
        expectFull = 1'b0;
        busIdle();
        repeat (resetCycles) @(negedge Clk);
        i_reset = 1'b0;

        currentTest = "window";                     // Kernel load, one window, status
        for (int k = 0; k < convPkg::windowTaps; k++) begin
            coefModel[k] = randomSample();
            wbWrite(busPkg::regCoef, coefModel[k]);
        end
        for (int k = 0; k < convPkg::windowTaps; k++) begin
            s = randomSample();
            sampleModel.push_back(s);
            wbWrite(busPkg::regSample, s);
        end
        startWindow();
        wbRead(busPkg::regControl, data);           // Busy expected here
        waitReady();
        wbRead(busPkg::regControl, data);
        wbRead(busPkg::regResult, data);

        currentTest = "backPressure";
        for (int i = 0; i < 17; i++) begin
            batch[i] = randomSample();
            sampleModel.push_back(batch[i]);
        end
        for (int i = 0; i < 16; i++) begin
            wbWrite(busPkg::regSample, batch[i]);
        end
        expectFull = 1'b1;
        wbRead(busPkg::regControl, data);           // Full bit set
        tryWrite(busPkg::regSample, batch[16], stallCycles, acked);
        startWindow();                              // Drains nine
        expectFull = 1'b0;
        if (!acked) begin
            wbWrite(busPkg::regSample, batch[16]);  // Retry the stalled pixel
        end
        waitReady();
        s = randomSample();
        sampleModel.push_back(s);
        wbWrite(busPkg::regSample, s);
        startWindow();
        waitReady();
        wbRead(busPkg::regResult, data);

        currentTest = "earlyStart";                 // Start with an empty FIFO
        for (int i = 0; i < convPkg::windowTaps; i++) begin
            batch[i] = randomSample();
            sampleModel.push_back(batch[i]);
        end
        startWindow();
        wbRead(busPkg::regControl, data);
        for (int i = 0; i < convPkg::windowTaps; i++) begin
            wbWrite(busPkg::regSample, batch[i]);
            @(negedge Clk);                         // Slow feed
        end
        waitReady();
        wbRead(busPkg::regResult, data);

        currentTest = "extremes";                   // Next window written while busy
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < convPkg::windowTaps; k++) begin
                s = extremeSample();
                sampleModel.push_back(s);
                wbWrite(busPkg::regSample, s);
            end
            if (w > 0) begin
                waitReady();
            end
            startWindow();
        end
        waitReady();
        wbRead(busPkg::regControl, data);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== compile.f ====
hw/convPkg.sv
hw/busPkg.sv
hw/laneIf.sv
hw/convBusPort.sv
hw/sampleFifo.sv
hw/tapCounter.sv
hw/convControl.sv
hw/macLanes.sv
hw/rowAccumulator.sv
hw/convTop.sv
verif/convTb.sv
